// ==== rtl/hazard_pkg.sv ====
// hazard control package: index widths, bus bit positions, command, bypass and pc enums
package hazard_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------

	// register index, x0..x31
	localparam int reg_idx_w = 5;

	// one enable per pipeline register
	localparam int enb_w = 4;

	// the writeback register is never flushed, so only three kill lines
	localparam int kill_w = 3;

	// x0 is hardwired, never a forwarding source
	localparam logic [reg_idx_w-1:0] reg_zero = '0;

	// ------------------------------------------------------------------
	// enable bus bit positions
	// ------------------------------------------------------------------

	localparam int REG_IF_DEC  = 0;
	localparam int REG_DEC_EXE = 1;
	localparam int REG_EXE_MEM = 2;
	localparam int REG_MEM_WB  = 3;

	// ------------------------------------------------------------------
	// kill bus bit positions
	// ------------------------------------------------------------------

	// same order as the enable bus, so bit n of both names one register
	localparam int KILL_IF_DEC  = 0;
	localparam int KILL_DEC_EXE = 1;
	localparam int KILL_EXE_MEM = 2;

	// ------------------------------------------------------------------
	// enums
	// ------------------------------------------------------------------

	// hazard command carried along with each instruction
	typedef enum logic [1:0] {
		HZRD_NONE  = 2'b00,
		HZRD_JUMP  = 2'b01,
		HZRD_BRNCH = 2'b10,
		HZRD_LOAD  = 2'b11
	} hzrd_cmd_e;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_MEM = 2'b01,
		FWD_WB  = 2'b10
	} fwd_sel_e;

	// next pc source, branches predicted not taken
	typedef enum logic {
		PC_SEQ    = 1'b0,
		PC_TARGET = 1'b1
	} pc_sel_e;

endpackage

// ==== rtl/pipe_view_if.sv ====
// pipe_view_if: stage view of indices, write enables, commands and stalls, with modports
`timescale 1ns/1ns

interface pipe_view_if
	import hazard_pkg::*;
();

	// source indices in execute and memory
	logic [reg_idx_w-1:0] exe_rs1;
	logic [reg_idx_w-1:0] exe_rs2;
	logic [reg_idx_w-1:0] mem_rs2;

	// destinations with their write enables
	logic [reg_idx_w-1:0] mem_rd;
	logic [reg_idx_w-1:0] wb_rd;
	logic                 mem_we;
	logic                 wb_we;

	// per-stage hazard commands
	hzrd_cmd_e cmd_dec;
	hzrd_cmd_e cmd_exe;
	hzrd_cmd_e cmd_mem;

	// branch outcome from the alu
	logic brnch_taken;

	// instruction cache and data cache not ready
	logic stall_dec;
	logic stall_wb;

	// the top level fills every field
	modport src (
		output exe_rs1, exe_rs2, mem_rs2, mem_rd, wb_rd,
		output mem_we, wb_we,
		output cmd_dec, cmd_exe, cmd_mem,
		output brnch_taken, stall_dec, stall_wb
	);

	modport fwd (
		input exe_rs1, exe_rs2, mem_rs2, mem_rd, wb_rd,
		input mem_we, wb_we, cmd_mem
	);

	modport flow (
		input cmd_dec, cmd_exe, cmd_mem,
		input brnch_taken, stall_dec, stall_wb
	);

endinterface

// ==== rtl/forward_unit.sv ====
// forward_unit: execute operand bypass selects, store data bypass and load-use detection
`timescale 1ns/1ns

module forward_unit
	import hazard_pkg::*;
(
	pipe_view_if.fwd view,
	output fwd_sel_e rs1_sel,
	output fwd_sel_e rs2_sel,
	output logic     store_wb,
	output logic     load_use,
	input  logic     clk
);

	// ------------------------------------------------------------------
	// destination matches
	// ------------------------------------------------------------------

	logic mem_is_load;
	logic mem_hit_rs1;
	logic mem_hit_rs2;
	logic wb_hit_rs1;
	logic wb_hit_rs2;

	// load data only shows up in writeback
	assign mem_is_load = (view.cmd_mem == HZRD_LOAD);

	assign mem_hit_rs1 = view.mem_we && (view.mem_rd == view.exe_rs1) &&
		(view.exe_rs1 != reg_zero);
	assign mem_hit_rs2 = view.mem_we && (view.mem_rd == view.exe_rs2) &&
		(view.exe_rs2 != reg_zero);

	assign wb_hit_rs1 = view.wb_we && (view.wb_rd == view.exe_rs1) &&
		(view.exe_rs1 != reg_zero);
	assign wb_hit_rs2 = view.wb_we && (view.wb_rd == view.exe_rs2) &&
		(view.exe_rs2 != reg_zero);

	// ------------------------------------------------------------------
	// source selection
	// ------------------------------------------------------------------

	// youngest producer wins, a load in memory falls back to writeback
	function automatic fwd_sel_e pick_src(
		input logic mem_hit,
		input logic wb_hit,
		input logic is_load
	);
		fwd_sel_e sel;
		sel = FWD_REG;
		if (mem_hit && !is_load) begin
			sel = FWD_MEM;
		end else if (wb_hit) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		rs1_sel = pick_src(mem_hit_rs1, wb_hit_rs1, mem_is_load);
		rs2_sel = pick_src(mem_hit_rs2, wb_hit_rs2, mem_is_load);
	end

	// store data in memory taken from the writeback result
	assign store_wb = view.wb_we && (view.wb_rd == view.mem_rs2) &&
		(view.mem_rs2 != reg_zero);

	// consumer in execute needs a load that is still in memory
	assign load_use = mem_is_load && (mem_hit_rs1 || mem_hit_rs2);

	// ------------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------------

	a_rs1_mem_nonzero: assert property (@(posedge clk)
		(rs1_sel == FWD_MEM) |-> (view.exe_rs1 != reg_zero));

	a_rs2_mem_nonzero: assert property (@(posedge clk)
		(rs2_sel == FWD_MEM) |-> (view.exe_rs2 != reg_zero));

endmodule

// ==== rtl/flow_ctrl_unit.sv ====
// flow_ctrl_unit: redirect, decode hold, icache bubble and dcache freeze requests
`timescale 1ns/1ns

module flow_ctrl_unit
	import hazard_pkg::*;
(
	pipe_view_if.flow view,
	output logic      redirect,
	output logic      dec_hold,
	output logic      icache_bubble,
	output logic      dcache_freeze,
	input  logic      clk
);

	// ------------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------------

	logic exe_jump;
	logic exe_brnch;
	logic dec_jump;
	logic mem_load;

	always_comb begin
		exe_jump  = (view.cmd_exe == HZRD_JUMP);
		exe_brnch = (view.cmd_exe == HZRD_BRNCH);
		dec_jump  = (view.cmd_dec == HZRD_JUMP);
		mem_load  = (view.cmd_mem == HZRD_LOAD);
	end

	// ------------------------------------------------------------------
	// control transfer
	// ------------------------------------------------------------------

	// target resolves in execute, a jump always goes,
	// a branch only when the alu says taken
	always_comb begin
		redirect = 1'b0;
		if (exe_jump) begin
			redirect = 1'b1;
		end else if (exe_brnch && view.brnch_taken) begin
			redirect = 1'b1;
		end
	end

	// jump seen in decode, stop fetching down the sequential path
	assign dec_hold = dec_jump;

	// ------------------------------------------------------------------
	// cache stalls
	// ------------------------------------------------------------------

	// no instruction yet, send a bubble into execute
	assign icache_bubble = view.stall_dec;

	// only a load waits on the data cache
	// a store miss is absorbed without stalling
	assign dcache_freeze = view.stall_wb && mem_load;

	// ------------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------------

	a_redirect_cmd: assert property (@(posedge clk)
		redirect |-> (view.cmd_exe inside {HZRD_JUMP, HZRD_BRNCH}));

endmodule

// ==== rtl/pipe_ctrl_merge.sv ====
// pipe_ctrl_merge: priority merge of hazard requests into enable bus, kill bus and pc select
`timescale 1ns/1ns

module pipe_ctrl_merge
	import hazard_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load_use,
	input  logic              redirect,
	input  logic              dec_hold,
	input  logic              icache_bubble,
	input  logic              dcache_freeze,
	output logic [enb_w-1:0]  enb_bus,
	output logic [kill_w-1:0] kill_bus,
	output pc_sel_e           pc_sel
);

	// ------------------------------------------------------------------
	// priority merge
	// ------------------------------------------------------------------

	always_comb begin
		enb_bus  = '1;
		kill_bus = '0;
		pc_sel   = PC_SEQ;

		if (!rst_n) begin
			// flush everything while in reset
			kill_bus = '1;
		end else if (dcache_freeze) begin
			// whole pipe waits for the data cache
			enb_bus = '0;
		end else if (load_use) begin
			// hold fetch and decode, bubble behind the load
			enb_bus[REG_IF_DEC]    = 1'b0;
			enb_bus[REG_DEC_EXE]   = 1'b0;
			kill_bus[KILL_EXE_MEM] = 1'b1;
		end else if (redirect) begin
			// drop the two wrong-path instructions
			pc_sel                 = PC_TARGET;
			kill_bus[KILL_IF_DEC]  = 1'b1;
			kill_bus[KILL_DEC_EXE] = 1'b1;
		end else begin
			// these two can stack
			if (dec_hold) begin
				enb_bus[REG_IF_DEC] = 1'b0;
			end
			if (icache_bubble) begin
				enb_bus[REG_IF_DEC]    = 1'b0;
				kill_bus[KILL_DEC_EXE] = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------------

	// a held register keeps its content, a killed one takes a bubble
	a_hold_xor_kill: assert property (@(posedge clk) disable iff (!rst_n)
		((~enb_bus[kill_w-1:0]) & kill_bus) == '0);

	// a freeze from flow control must never let a redirect through
	a_no_target_in_freeze: assert property (@(posedge clk) disable iff (!rst_n)
		(pc_sel == PC_TARGET) |-> !dcache_freeze);

endmodule

// ==== rtl/core_hazard_ctrl.sv ====
// core_hazard_ctrl: hazard control top, forwarding and flow control with priority merge
`timescale 1ns/1ns

module core_hazard_ctrl
	import hazard_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	// sources and destinations
	input  logic [reg_idx_w-1:0] exe_rs1,
	input  logic [reg_idx_w-1:0] exe_rs2,
	input  logic [reg_idx_w-1:0] mem_rs2,
	input  logic [reg_idx_w-1:0] mem_rd,
	input  logic [reg_idx_w-1:0] wb_rd,
	input  logic                 mem_we,
	input  logic                 wb_we,
	// stage commands
	input  hzrd_cmd_e            cmd_dec,
	input  hzrd_cmd_e            cmd_exe,
	input  hzrd_cmd_e            cmd_mem,
	input  logic                 brnch_taken,
	// cache stalls
	input  logic                 stall_dec,
	input  logic                 stall_wb,
	// bypass selects
	output fwd_sel_e             fwd_rs1_sel,
	output fwd_sel_e             fwd_rs2_sel,
	output logic                 fwd_store_wb,
	// pipeline register control
	output logic [enb_w-1:0]     enb_bus,
	output logic [kill_w-1:0]    kill_bus,
	output pc_sel_e              pc_sel
);

	logic load_use;
	logic redirect;
	logic dec_hold;
	logic icache_bubble;
	logic dcache_freeze;

	// ------------------------------------------------------------------
	// stage view
	// ------------------------------------------------------------------

	pipe_view_if view ();

	assign view.exe_rs1     = exe_rs1;
	assign view.exe_rs2     = exe_rs2;
	assign view.mem_rs2     = mem_rs2;
	assign view.mem_rd      = mem_rd;
	assign view.wb_rd       = wb_rd;
	assign view.mem_we      = mem_we;
	assign view.wb_we       = wb_we;
	assign view.cmd_dec     = cmd_dec;
	assign view.cmd_exe     = cmd_exe;
	assign view.cmd_mem     = cmd_mem;
	assign view.brnch_taken = brnch_taken;
	assign view.stall_dec   = stall_dec;
	assign view.stall_wb    = stall_wb;

	// ------------------------------------------------------------------
	// hazard units
	// ------------------------------------------------------------------

	forward_unit u_forward_unit (
		.view     (view),
		.rs1_sel  (fwd_rs1_sel),
		.rs2_sel  (fwd_rs2_sel),
		.store_wb (fwd_store_wb),
		.load_use (load_use),
		.clk      (clk)
	);

	flow_ctrl_unit u_flow_ctrl_unit (
		.view          (view),
		.redirect      (redirect),
		.dec_hold      (dec_hold),
		.icache_bubble (icache_bubble),
		.dcache_freeze (dcache_freeze),
		.clk           (clk)
	);

	pipe_ctrl_merge u_pipe_ctrl_merge (
		.clk           (clk),
		.rst_n         (rst_n),
		.load_use      (load_use),
		.redirect      (redirect),
		.dec_hold      (dec_hold),
		.icache_bubble (icache_bubble),
		.dcache_freeze (dcache_freeze),
		.enb_bus       (enb_bus),
		.kill_bus      (kill_bus),
		.pc_sel        (pc_sel)
	);

endmodule

// ==== verification/tb_core_hazard_ctrl.sv ====
// testbench for the hazard control top: clock, reset, xorshift stimulus, reference rules, checks
`timescale 1ns/1ns

module tb_core_hazard_ctrl
	import hazard_pkg::*;
();

	localparam int half_period = 20;
	localparam int rst_cycles  = 5;
	localparam int test_cycles = 200;
	// reset plus five tests take 1005 cycles, leave some margin
	localparam int cycle_limit = 1500;
	localparam logic [31:0] seed = 32'h6a4aea7a;

	logic clk = 1'b0;
	logic rst_n;
	logic [reg_idx_w-1:0] exe_rs1;
	logic [reg_idx_w-1:0] exe_rs2;
	logic [reg_idx_w-1:0] mem_rs2;
	logic [reg_idx_w-1:0] mem_rd;
	logic [reg_idx_w-1:0] wb_rd;
	logic mem_we;
	logic wb_we;
	hzrd_cmd_e cmd_dec;
	hzrd_cmd_e cmd_exe;
	hzrd_cmd_e cmd_mem;
	logic brnch_taken;
	logic stall_dec;
	logic stall_wb;
	fwd_sel_e fwd_rs1_sel;
	fwd_sel_e fwd_rs2_sel;
	logic fwd_store_wb;
	logic [enb_w-1:0] enb_bus;
	logic [kill_w-1:0] kill_bus;
	pc_sel_e pc_sel;

	// reference values
	fwd_sel_e exp_rs1;
	fwd_sel_e exp_rs2;
	logic exp_store;
	logic exp_lu;
	logic [enb_w-1:0] exp_enb;
	logic [kill_w-1:0] exp_kill;
	pc_sel_e exp_pc;

	logic [31:0] rng_state = seed;
	string cur_test = "init";
	int cur_id = -1;
	logic target_hit;
	int hit_cnt = 0;
	int err_cnt = 0;
	int cycle_cnt = 0;
	int pass_tests = 0;
	int fail_tests = 0;

	always #half_period clk = ~clk;

	core_hazard_ctrl u_core_hazard_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.exe_rs1      (exe_rs1),
		.exe_rs2      (exe_rs2),
		.mem_rs2      (mem_rs2),
		.mem_rd       (mem_rd),
		.wb_rd        (wb_rd),
		.mem_we       (mem_we),
		.wb_we        (wb_we),
		.cmd_dec      (cmd_dec),
		.cmd_exe      (cmd_exe),
		.cmd_mem      (cmd_mem),
		.brnch_taken  (brnch_taken),
		.stall_dec    (stall_dec),
		.stall_wb     (stall_wb),
		.fwd_rs1_sel  (fwd_rs1_sel),
		.fwd_rs2_sel  (fwd_rs2_sel),
		.fwd_store_wb (fwd_store_wb),
		.enb_bus      (enb_bus),
		.kill_bus     (kill_bus),
		.pc_sel       (pc_sel)
	);

	// ----------------------------------------------------------------------
	// reference rules
	// ----------------------------------------------------------------------

	// a producer counts only with a nonzero index and its write enable
	function automatic logic writes_to(
		input logic [reg_idx_w-1:0] rd,
		input logic we,
		input logic [reg_idx_w-1:0] idx
	);
		return we && (rd == idx) && (idx != '0);
	endfunction

	function automatic fwd_sel_e operand_source(input logic [reg_idx_w-1:0] idx);
		if (writes_to(mem_rd, mem_we, idx) && cmd_mem != HZRD_LOAD) begin
			return FWD_MEM;
		end
		if (writes_to(wb_rd, wb_we, idx)) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	always_comb begin
		exp_rs1   = operand_source(exe_rs1);
		exp_rs2   = operand_source(exe_rs2);
		exp_store = writes_to(wb_rd, wb_we, mem_rs2);
		exp_lu    = (cmd_mem == HZRD_LOAD) &&
			(writes_to(mem_rd, mem_we, exe_rs1) || writes_to(mem_rd, mem_we, exe_rs2));
	end

	// priority order, freeze first and default last
	always_comb begin
		exp_enb  = 4'b1111;
		exp_kill = 3'b000;
		exp_pc   = PC_SEQ;
		if (!rst_n) begin
			exp_kill = 3'b111;
		end else if (stall_wb && cmd_mem == HZRD_LOAD) begin
			exp_enb = 4'b0000;
		end else if (exp_lu) begin
			exp_enb  = 4'b1100;
			exp_kill = 3'b100;
		end else if (cmd_exe == HZRD_JUMP || (cmd_exe == HZRD_BRNCH && brnch_taken)) begin
			exp_pc   = PC_TARGET;
			exp_kill = 3'b011;
		end else begin
			if (cmd_dec == HZRD_JUMP || stall_dec) begin
				exp_enb[REG_IF_DEC] = 1'b0;
			end
			if (stall_dec) begin
				exp_kill[KILL_DEC_EXE] = 1'b1;
			end
		end
	end

	// condition that each test must reach at least once
	always_comb begin
		case (cur_id)
			0: target_hit = !rst_n;
			1: target_hit = (exp_rs1 == FWD_MEM) || (exp_rs2 == FWD_WB);
			2: target_hit = exp_store;
			3: target_hit = exp_lu;
			4: target_hit = (exp_pc == PC_TARGET);
			5: target_hit = stall_wb && (cmd_mem == HZRD_LOAD);
			default: target_hit = 1'b0;
		endcase
	end

	always @(negedge clk) begin
		if (target_hit) begin
			hit_cnt <= hit_cnt + 1;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	task automatic report_mismatch(input string sig, input logic [3:0] exp, input logic [3:0] act);
		$display("mismatch %s %s expected %0h actual %0h", cur_test, sig, exp, act);
		err_cnt++;
	endtask

	a_rs1: assert property (@(negedge clk) fwd_rs1_sel == exp_rs1)
		else report_mismatch("fwd_rs1_sel", 4'(exp_rs1), 4'(fwd_rs1_sel));
	a_rs2: assert property (@(negedge clk) fwd_rs2_sel == exp_rs2)
		else report_mismatch("fwd_rs2_sel", 4'(exp_rs2), 4'(fwd_rs2_sel));
	a_store: assert property (@(negedge clk) fwd_store_wb == exp_store)
		else report_mismatch("fwd_store_wb", 4'(exp_store), 4'(fwd_store_wb));
	a_enb: assert property (@(negedge clk) enb_bus == exp_enb)
		else report_mismatch("enb_bus", exp_enb, enb_bus);
	a_kill: assert property (@(negedge clk) kill_bus == exp_kill)
		else report_mismatch("kill_bus", 4'(exp_kill), 4'(kill_bus));
	a_pc: assert property (@(negedge clk) pc_sel == exp_pc)
		else report_mismatch("pc_sel", 4'(exp_pc), 4'(pc_sel));

	// load data is not there yet in memory
	a_load_not_from_mem: assert property (@(negedge clk)
		(cmd_mem == HZRD_LOAD) |-> (fwd_rs1_sel != FWD_MEM && fwd_rs2_sel != FWD_MEM))
		else begin
			$display("operand taken from the memory stage while it holds a load in %s",
				cur_test);
			err_cnt++;
		end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	// 32-bit xorshift, state advances on every call
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// indices limited to x0..x3 so matches are frequent
	task automatic drive_stimulus(input int id);
		logic [31:0] r0;
		logic [31:0] r1;
		hzrd_cmd_e c_dec;
		hzrd_cmd_e c_exe;
		hzrd_cmd_e c_mem;
		logic s_dec;
		logic s_wb;
		logic we_mem;
		r0 = next_random();
		r1 = next_random();
		c_dec  = HZRD_NONE;
		c_exe  = HZRD_NONE;
		c_mem  = HZRD_NONE;
		s_dec  = 1'b0;
		s_wb   = 1'b0;
		we_mem = r0[10];
		case (id)
			0, 5: begin
				c_dec = hzrd_cmd_e'(r1[1:0]);
				c_exe = hzrd_cmd_e'(r1[3:2]);
				c_mem = hzrd_cmd_e'(r1[5:4]);
				s_dec = r1[6];
				s_wb  = r1[7];
			end
			3: begin
				c_mem  = (r1[1:0] != 2'b00) ? HZRD_LOAD : HZRD_NONE;
				we_mem = 1'b1;
			end
			4: begin
				c_dec = hzrd_cmd_e'(r1[1:0]);
				c_exe = hzrd_cmd_e'(r1[3:2]);
			end
			default: begin
			end
		endcase
		rst_n       <= (id != 0);
		exe_rs1     <= reg_idx_w'(r0[1:0]);
		exe_rs2     <= reg_idx_w'(r0[3:2]);
		mem_rs2     <= reg_idx_w'(r0[5:4]);
		mem_rd      <= reg_idx_w'(r0[7:6]);
		wb_rd       <= reg_idx_w'(r0[9:8]);
		mem_we      <= we_mem;
		wb_we       <= r0[11];
		brnch_taken <= r0[12];
		cmd_dec     <= c_dec;
		cmd_exe     <= c_exe;
		cmd_mem     <= c_mem;
		stall_dec   <= s_dec;
		stall_wb    <= s_wb;
	endtask

	// starts and ends on a rising edge
	task automatic run_test(input string name, input int id, input int n_cycles);
		int err_base;
		int hit_base;
		int errs;
		err_base = err_cnt;
		hit_base = hit_cnt;
		cur_test = name;
		cur_id   = id;
		repeat (n_cycles) begin
			drive_stimulus(id);
			@(posedge clk);
		end
		errs = err_cnt - err_base;
		if (hit_cnt == hit_base) begin
			$display("test %s failed: its target condition never came up", name);
			fail_tests++;
		end else if (errs != 0) begin
			$display("test %s failed with %0d errors", name, errs);
			fail_tests++;
		end else begin
			$display("test %s passed", name);
			pass_tests++;
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		rst_n       <= 1'b0;
		exe_rs1     <= '0;
		exe_rs2     <= '0;
		mem_rs2     <= '0;
		mem_rd      <= '0;
		wb_rd       <= '0;
		mem_we      <= 1'b0;
		wb_we       <= 1'b0;
		cmd_dec     <= HZRD_NONE;
		cmd_exe     <= HZRD_NONE;
		cmd_mem     <= HZRD_NONE;
		brnch_taken <= 1'b0;
		stall_dec   <= 1'b0;
		stall_wb    <= 1'b0;
		@(posedge clk);
		run_test("reset", 0, rst_cycles);
		run_test("operand_fwd", 1, test_cycles);
		run_test("store_bypass", 2, test_cycles);
		run_test("load_use", 3, test_cycles);
		run_test("redirect", 4, test_cycles);
		run_test("cache_stall", 5, test_cycles);
		$display("tests passed %0d failed %0d errors %0d", pass_tests, fail_tests, err_cnt);
		if (fail_tests == 0 && err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== src.f ====
rtl/hazard_pkg.sv
rtl/pipe_view_if.sv
rtl/forward_unit.sv
rtl/flow_ctrl_unit.sv
rtl/pipe_ctrl_merge.sv
rtl/core_hazard_ctrl.sv
verification/tb_core_hazard_ctrl.sv

// ==== Makefile ====
# Verilator build for the hazard control subsystem

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_core_hazard_ctrl
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx -- '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
